// File: Bender.yml
package:
  name: commu_sys

sources:
  - include_dirs:
      - src
    files:
      - src/commu_pkg.sv
      - src/pkt_buf_if.sv
      - src/pkt_buffer.sv
      - src/arm_rd_port.sv
      - src/arm_int_ctrl.sv
      - src/commu_sys.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - verif/tb_commu_sys.sv

// File: commu_sys.f
+incdir+src
src/commu_pkg.sv
src/pkt_buf_if.sv
src/pkt_buffer.sv
src/arm_rd_port.sv
src/arm_int_ctrl.sv
src/commu_sys.sv
verif/tb_commu_sys.sv

// File: src/arm_int_ctrl.sv
/* arm_int_ctrl raises the ARM interrupt while packets wait, with
   power-on delay, acknowledge release, watchdog flush and holdoff */
`timescale 1ns/1ps
`default_nettype none
`include "commu_cfg.svh"

module arm_int_ctrl (
	input  logic          clk_sys,
	input  logic          rst_n,
	input  logic          buf_frm,
	output logic          arm_int_n,
	output logic [7:0]    stu_buf_rdy,
	output logic          rd_grant,
	pkt_buf_if.ctrl_side  bus
);

	localparam int POR_W  = $clog2(`COMMU_T_POR);
	localparam int WD_W   = $clog2(`COMMU_T_WD + 1);
	localparam int DOWN_W = $clog2(`COMMU_T_DOWN + 1);
	localparam logic [POR_W-1:0]  POR_LAST  = POR_W'(`COMMU_T_POR - 1);
	// the interrupt drops two cycles after the watchdog fires
	localparam logic [WD_W-1:0]   WD_LAST   = WD_W'(`COMMU_T_WD - 2);
	localparam logic [DOWN_W-1:0] DOWN_LAST = DOWN_W'(`COMMU_T_DOWN - 1);

	commu_pkg::int_state_e st;
	commu_pkg::int_state_e st_nxt;
	logic [POR_W-1:0]      por_cnt;
	logic [WD_W-1:0]       wd_cnt;
	logic [DOWN_W-1:0]     down_cnt;
	logic                  buf_frm_d;
	logic                  buf_rise;
	logic                  por_done;
	logic                  wd_fire;
	logic                  down_done;
	logic                  arm_int;
	logic                  release_q;
	logic                  flush_q;

	assign buf_rise  = ~buf_frm_d & buf_frm;
	assign por_done  = (por_cnt == POR_LAST);
	assign wd_fire   = (st == commu_pkg::S_UP) && (wd_cnt == WD_LAST);
	assign down_done = (down_cnt == DOWN_LAST);

	// ------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------
	always_comb begin
		st_nxt = st;
		case (st)
			commu_pkg::S_RST:
				if (por_done)
					st_nxt = commu_pkg::S_IDLE;
			commu_pkg::S_IDLE:
				if (bus.pkg_cnt != '0)
					st_nxt = commu_pkg::S_UP;
			commu_pkg::S_UP:
				if (wd_fire || buf_rise)
					st_nxt = commu_pkg::S_DOWN;
			commu_pkg::S_DOWN:
				if (down_done)
					st_nxt = commu_pkg::S_DONE;
			commu_pkg::S_DONE:
				st_nxt = commu_pkg::S_IDLE;
			default:
				st_nxt = commu_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			st        <= commu_pkg::S_RST;
			buf_frm_d <= 1'b0;
			arm_int   <= 1'b0;
			release_q <= 1'b0;
			flush_q   <= 1'b0;
		end else begin
			st        <= st_nxt;
			buf_frm_d <= buf_frm;
			// high the cycle after each cycle in UP
			arm_int   <= (st == commu_pkg::S_UP);
			// watchdog has priority over a late acknowledge
			release_q <= (st == commu_pkg::S_UP) & buf_rise & ~wd_fire;
			flush_q   <= wd_fire;
		end
	end

	// ------------------------------------------------------------
	// power-on, watchdog and holdoff counters
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			por_cnt  <= '0;
			wd_cnt   <= '0;
			down_cnt <= '0;
		end else begin
			if (!por_done)
				por_cnt <= por_cnt + 1'b1;

			if (arm_int)
				wd_cnt <= wd_cnt + 1'b1;
			else
				wd_cnt <= '0;

			if (st == commu_pkg::S_DOWN)
				down_cnt <= down_cnt + 1'b1;
			else
				down_cnt <= '0;
		end
	end

	assign arm_int_n       = ~arm_int;
	assign stu_buf_rdy     = {8{arm_int}};
	assign rd_grant        = arm_int;
	assign bus.pkt_release = release_q;
	assign bus.flush       = flush_q;

	a_release_xor_flush: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(bus.pkt_release && bus.flush))
		else $error("release and flush in the same cycle");

endmodule

`default_nettype wire

// File: src/arm_rd_port.sv
/* arm_rd_port serves head-packet words to the ARM one per request
   while the control grants reads */
`timescale 1ns/1ps
`default_nettype none
`include "commu_cfg.svh"

module arm_rd_port (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 rd_req,
	input  logic                 rd_grant,
	output commu_pkg::pkt_word_t rd_data,
	output logic                 rd_valid,
	pkt_buf_if.rd_side           bus
);

	commu_pkg::pkt_len_t served;
	logic                pkt_done;
	logic                rd_ok;

	// request honoured only while words remain in the head packet
	assign rd_ok = rd_req & rd_grant & ~pkt_done & (served < bus.head_len);

	assign bus.rd_pop = rd_ok;

	// ------------------------------------------------------------
	// word count and valid strobe
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			served   <= '0;
			pkt_done <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_ok;
			// count restarts once the grant drops
			if (!rd_grant) begin
				served   <= '0;
				pkt_done <= 1'b0;
			end else if (rd_ok) begin
				served   <= served + 1'b1;
				pkt_done <= bus.rd_last;
			end
		end
	end

	// data follows the request by one cycle
	always_ff @(posedge clk_sys) begin
		if (rd_ok)
			rd_data <= bus.rd_word;
	end

	a_valid_granted: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(rd_valid) |-> $past(rd_grant))
		else $error("rd_valid without a read grant");

endmodule

`default_nettype wire

// File: src/commu_cfg.svh
/* commu configuration for the ARM packet buffer
   buffer depth, packet limits and timer lengths at simulation scale */
`ifndef COMMU_CFG_SVH
`define COMMU_CFG_SVH

// data path
`define COMMU_WORD_W       16
`define COMMU_BUF_DEPTH    64

// packet limits
`define COMMU_MAX_PKT_LEN  16
// largest value of the 4-bit packet count
`define COMMU_MAX_PKTS     15

// ------------------------------------------------------------
// timers in clk_sys cycles
// ------------------------------------------------------------
// power-on delay before the first interrupt
`define COMMU_T_POR        64
// interrupt held without acknowledge
`define COMMU_T_WD         300
// holdoff between interrupts
`define COMMU_T_DOWN       20

`endif

// File: src/commu_pkg.sv
/* commu_pkg holds the word, count, length and control state types
   shared by the packet buffer blocks */
`default_nettype none
`include "commu_cfg.svh"

package commu_pkg;

	// one data word from the repacker
	typedef logic [`COMMU_WORD_W-1:0] pkt_word_t;

	// complete packets waiting for the ARM
	typedef logic [$clog2(`COMMU_MAX_PKTS + 1)-1:0] pkt_cnt_t;

	// packet length in words, 0 up to the max length
	typedef logic [$clog2(`COMMU_MAX_PKT_LEN + 1)-1:0] pkt_len_t;

	// word memory address
	typedef logic [$clog2(`COMMU_BUF_DEPTH)-1:0] buf_addr_t;

	// interrupt control states
	typedef enum logic [2:0] {
		S_IDLE = 3'h0,
		S_UP   = 3'h2,
		S_DOWN = 3'h3,
		S_RST  = 3'h6,
		S_DONE = 3'h7
	} int_state_e;

endpackage

`default_nettype wire

// File: src/commu_sys.sv
/* commu_sys packet buffer between the repacker and the ARM,
   joining store, read port and interrupt control */
`timescale 1ns/1ps
`default_nettype none
`include "commu_cfg.svh"

module commu_sys (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	// repacker side
	input  logic                 repk_frm,
	input  logic                 wr_valid,
	input  commu_pkg::pkt_word_t wr_data,
	// ARM side
	input  logic                 rd_req,
	input  logic                 buf_frm,
	output commu_pkg::pkt_word_t rd_data,
	output logic                 rd_valid,
	output logic                 arm_int_n,
	output logic [7:0]           stu_buf_rdy,
	output commu_pkg::pkt_cnt_t  pkt_cnt
);

	logic rd_grant;

	pkt_buf_if i_bus (
		.clk_sys (clk_sys)
	);

	pkt_buffer i_buf (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.repk_frm (repk_frm),
		.wr_valid (wr_valid),
		.wr_data  (wr_data),
		.bus      (i_bus.buf_side)
	);

	arm_rd_port i_rd (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.rd_req   (rd_req),
		.rd_grant (rd_grant),
		.rd_data  (rd_data),
		.rd_valid (rd_valid),
		.bus      (i_bus.rd_side)
	);

	arm_int_ctrl i_ctrl (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.buf_frm     (buf_frm),
		.arm_int_n   (arm_int_n),
		.stu_buf_rdy (stu_buf_rdy),
		.rd_grant    (rd_grant),
		.bus         (i_bus.ctrl_side)
	);

	// packet count as status
	assign pkt_cnt = i_bus.pkg_cnt;

endmodule

`default_nettype wire

// File: src/pkt_buf_if.sv
/* pkt_buf_if carries packet status, release and flush pulses
   and head-packet reads between buffer, read port and control */
`timescale 1ns/1ps
`default_nettype none
`include "commu_cfg.svh"

interface pkt_buf_if (
	input logic clk_sys
);

	// buffer status
	commu_pkg::pkt_cnt_t  pkg_cnt;
	commu_pkg::pkt_len_t  head_len;

	// one-cycle pulses from the control
	logic                 pkt_release;
	logic                 flush;

	// head packet read path
	logic                 rd_pop;
	commu_pkg::pkt_word_t rd_word;
	logic                 rd_last;

	modport buf_side (
		input  clk_sys,
		output pkg_cnt, head_len, rd_word, rd_last,
		input  pkt_release, flush, rd_pop
	);

	modport ctrl_side (
		input  clk_sys,
		input  pkg_cnt,
		output pkt_release, flush
	);

	modport rd_side (
		input  clk_sys,
		output rd_pop,
		input  rd_word, rd_last, head_len
	);

endinterface

`default_nettype wire

// File: src/pkt_buffer.sv
/* pkt_buffer stores repacked frames in a circular word memory
   and queues their lengths for the ARM, with release and flush */
`timescale 1ns/1ps
`default_nettype none
`include "commu_cfg.svh"

module pkt_buffer (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 repk_frm,
	input  logic                 wr_valid,
	input  commu_pkg::pkt_word_t wr_data,
	pkt_buf_if.buf_side          bus
);

	localparam int ADDR_W = $bits(commu_pkg::buf_addr_t);
	localparam int Q_W    = $bits(commu_pkg::pkt_cnt_t);
	localparam logic [ADDR_W:0] DEPTH = (ADDR_W + 1)'(`COMMU_BUF_DEPTH);
	localparam commu_pkg::pkt_len_t MAX_LEN  = commu_pkg::pkt_len_t'(`COMMU_MAX_PKT_LEN);
	localparam commu_pkg::pkt_cnt_t MAX_PKTS = commu_pkg::pkt_cnt_t'(`COMMU_MAX_PKTS);

	commu_pkg::pkt_word_t mem [`COMMU_BUF_DEPTH];
	commu_pkg::pkt_len_t  len_q [2**Q_W];

	// pointers carry one wrap bit
	logic [ADDR_W:0]      wr_ptr;
	logic [ADDR_W:0]      rd_ptr;
	logic [ADDR_W:0]      pkt_start;
	logic [ADDR_W:0]      used;
	logic [Q_W-1:0]       q_wr;
	logic [Q_W-1:0]       q_rd;
	commu_pkg::pkt_cnt_t  pkg_cnt;
	commu_pkg::pkt_len_t  cur_len;
	commu_pkg::pkt_len_t  pend_len;
	commu_pkg::pkt_len_t  rd_off;
	commu_pkg::buf_addr_t rd_addr;
	logic                 repk_frm_d;
	logic                 cur_bad;
	logic                 pend_ok;
	logic                 frm_fall;
	logic                 wr_try;
	logic                 wr_ok;
	logic                 pkt_drop;
	logic                 commit;

	// ------------------------------------------------------------
	// write side
	// ------------------------------------------------------------
	assign frm_fall = repk_frm_d & ~repk_frm;
	assign used     = wr_ptr - rd_ptr;
	assign wr_try   = repk_frm & wr_valid & ~cur_bad;
	// word lost when the packet is too long or memory is full
	assign wr_ok    = wr_try & (cur_len != MAX_LEN) & (used != DEPTH);
	assign pkt_drop = cur_bad | (cur_len == '0) | (pkg_cnt == MAX_PKTS);
	// a flush wins over a completing packet
	assign commit   = pend_ok & ~bus.flush;

	always_ff @(posedge clk_sys) begin
		if (wr_ok)
			mem[wr_ptr[ADDR_W-1:0]] <= wr_data;
		if (frm_fall)
			pend_len <= cur_len;
		if (commit)
			len_q[q_wr] <= pend_len;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			repk_frm_d <= 1'b0;
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			pkt_start  <= '0;
			q_wr       <= '0;
			q_rd       <= '0;
			pkg_cnt    <= '0;
			cur_len    <= '0;
			rd_off     <= '0;
			cur_bad    <= 1'b0;
			pend_ok    <= 1'b0;
		end else begin
			repk_frm_d <= repk_frm;
			if (bus.flush) begin
				wr_ptr    <= '0;
				rd_ptr    <= '0;
				pkt_start <= '0;
				q_wr      <= '0;
				q_rd      <= '0;
				pkg_cnt   <= '0;
				cur_len   <= '0;
				rd_off    <= '0;
				// a frame still open loses its earlier words
				cur_bad   <= repk_frm;
				pend_ok   <= 1'b0;
			end else begin
				pend_ok <= frm_fall & ~pkt_drop;
				if (frm_fall) begin
					cur_len <= '0;
					cur_bad <= 1'b0;
					if (pkt_drop)
						wr_ptr <= pkt_start;
					else
						pkt_start <= wr_ptr;
				end else if (wr_ok) begin
					wr_ptr  <= wr_ptr + 1'b1;
					cur_len <= cur_len + 1'b1;
				end else if (wr_try) begin
					cur_bad <= 1'b1;
				end

				if (commit)
					q_wr <= q_wr + 1'b1;

				// release drops the head packet and rewinds the offset
				if (bus.pkt_release) begin
					rd_ptr <= rd_ptr + (ADDR_W + 1)'(len_q[q_rd]);
					q_rd   <= q_rd + 1'b1;
					rd_off <= '0;
				end else if (bus.rd_pop) begin
					rd_off <= rd_off + 1'b1;
				end

				pkg_cnt <= pkg_cnt + commu_pkg::pkt_cnt_t'(commit)
					- commu_pkg::pkt_cnt_t'(bus.pkt_release);
			end
		end
	end

	// ------------------------------------------------------------
	// head packet view
	// ------------------------------------------------------------
	assign rd_addr      = rd_ptr[ADDR_W-1:0] + commu_pkg::buf_addr_t'(rd_off);
	assign bus.pkg_cnt  = pkg_cnt;
	assign bus.head_len = (pkg_cnt != '0) ? len_q[q_rd] : '0;
	assign bus.rd_word  = mem[rd_addr];
	assign bus.rd_last  = (bus.head_len != '0) && (rd_off == bus.head_len - 1'b1);

	a_release_pending: assert property (@(posedge clk_sys) disable iff (!rst_n)
		bus.pkt_release |-> (pkg_cnt != '0))
		else $error("release with no packet waiting");

	// a commit at the limit would carry the count past it
	a_cnt_limit: assert property (@(posedge clk_sys) disable iff (!rst_n)
		commit && (pkg_cnt == MAX_PKTS) |-> bus.pkt_release)
		else $error("packet count above limit");

endmodule

`default_nettype wire

// File: verif/tb_commu_sys.sv
/* testbench for the ARM packet buffer, table-driven packet loads
   with LFSR data checked against a reference queue */
`timescale 1ns/1ps
`default_nettype none
`include "commu_cfg.svh"

module tb_commu_sys;

	localparam int N_ENTRIES = 9;
	localparam int CYC_LIMIT = `COMMU_T_POR + 16 + N_ENTRIES *
		(`COMMU_T_WD + `COMMU_T_DOWN + 2 * `COMMU_MAX_PKT_LEN + 50);
	localparam logic [1:0] MODE_ACK  = 2'd0;
	localparam logic [1:0] MODE_WDOG = 2'd1;
	localparam logic [1:0] MODE_DROP = 2'd2;

	typedef struct packed {
		logic [1:0]          mode;
		logic [4:0]          len;
		logic [4:0]          npkt;
		commu_pkg::pkt_cnt_t exp_cnt;
	} entry_t;

	// mode, words per packet, packets loaded, pkt_cnt after the load
	localparam entry_t STIM [N_ENTRIES] = '{
		'{MODE_ACK,  5'd4,  5'd1,  4'd1},
		'{MODE_ACK,  5'd7,  5'd3,  4'd3},
		'{MODE_WDOG, 5'd5,  5'd2,  4'd2},
		'{MODE_ACK,  5'd16, 5'd1,  4'd1},
		// overlong, empty, memory full, packet limit
		'{MODE_DROP, 5'd17, 5'd2,  4'd0},
		'{MODE_DROP, 5'd0,  5'd3,  4'd0},
		'{MODE_DROP, 5'd16, 5'd5,  4'd4},
		'{MODE_DROP, 5'd4,  5'd16, 4'd15},
		'{MODE_ACK,  5'd1,  5'd2,  4'd2}
	};

	logic                  clk_sys;
	logic                  rst_n;
	logic                  repk_frm;
	logic                  wr_valid;
	commu_pkg::pkt_word_t  wr_data;
	logic                  rd_req;
	logic                  buf_frm;
	commu_pkg::pkt_word_t  rd_data;
	logic                  rd_valid;
	logic                  arm_int_n;
	logic [7:0]            stu_buf_rdy;
	commu_pkg::pkt_cnt_t   pkt_cnt;

	commu_pkg::pkt_word_t  ref_q [$];
	int                    len_q [$];
	logic [31:0]           lfsr;
	int                    cyc = 0;
	int                    rst_cyc = 0;
	int                    low_run = 0;
	commu_pkg::int_state_e ctrl_st;

	commu_sys i_dut (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.repk_frm    (repk_frm),
		.wr_valid    (wr_valid),
		.wr_data     (wr_data),
		.rd_req      (rd_req),
		.buf_frm     (buf_frm),
		.rd_data     (rd_data),
		.rd_valid    (rd_valid),
		.arm_int_n   (arm_int_n),
		.stu_buf_rdy (stu_buf_rdy),
		.pkt_cnt     (pkt_cnt)
	);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	// ------------------------------------------------------------
	// cycle limit and interrupt pulse length
	// ------------------------------------------------------------
	always @(posedge clk_sys) begin
		cyc <= cyc + 1;
		if (arm_int_n === 1'b0)
			low_run <= low_run + 1;
		else
			low_run <= 0;
		if (cyc > CYC_LIMIT) begin
			ctrl_st = i_dut.i_ctrl.st;
			$display("timeout after %0d cycles with control in %s", cyc, ctrl_st.name());
			abort_run();
		end
	end

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	// sample outputs, then drive inputs, 10 ns after the edge
	task automatic step();
		@(posedge clk_sys);
		#10;
	endtask

	// right-shift Galois form, taps 32 31 29 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'hD000_0001;
		return s >> 1;
	endfunction

	task automatic take_word(output commu_pkg::pkt_word_t w);
		for (int b = 0; b < `COMMU_WORD_W; b++) begin
			w[b] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic check_word(input commu_pkg::pkt_word_t exp);
		if (rd_data !== exp) begin
			$display("FAILED rd_data: got %h expected %h", rd_data, exp);
			abort_run();
		end
	endtask

	task automatic check_cnt(input commu_pkg::pkt_cnt_t exp);
		if (pkt_cnt !== exp) begin
			$display("FAILED pkt_cnt: got %h expected %h", pkt_cnt, exp);
			abort_run();
		end
	endtask

	task automatic check_int(input logic exp_n, input logic [7:0] exp_rdy);
		if (arm_int_n !== exp_n || stu_buf_rdy !== exp_rdy) begin
			$display("FAILED arm_int_n/stu_buf_rdy: got %h/%h expected %h/%h",
				arm_int_n, stu_buf_rdy, exp_n, exp_rdy);
			abort_run();
		end
	endtask

	task automatic check_valid(input logic exp);
		if (rd_valid !== exp) begin
			$display("FAILED rd_valid: got %h expected %h", rd_valid, exp);
			abort_run();
		end
	endtask

	task automatic check_span(input string what, input int got, input int lo, input int hi);
		if (got < lo || got > hi) begin
			$display("FAILED %s: got %h expected %h to %h", what, got, lo, hi);
			abort_run();
		end
	endtask

	// ------------------------------------------------------------
	// repacker and ARM actions
	// ------------------------------------------------------------
	task automatic send_pkt(input int len);
		commu_pkg::pkt_word_t w;
		bit keep;
		// kept only when length, free words and packet count allow
		keep = (len > 0) && (len <= `COMMU_MAX_PKT_LEN) &&
			(ref_q.size() + len <= `COMMU_BUF_DEPTH) && (len_q.size() < `COMMU_MAX_PKTS);
		if (len == 0) begin
			repk_frm = 1'b1;
			wr_valid = 1'b0;
			step();
		end
		for (int i = 0; i < len; i++) begin
			take_word(w);
			repk_frm = 1'b1;
			wr_valid = 1'b1;
			wr_data  = w;
			if (keep)
				ref_q.push_back(w);
			step();
		end
		repk_frm = 1'b0;
		wr_valid = 1'b0;
		step();
		if (keep)
			len_q.push_back(len);
	endtask

	task automatic wait_int_low(output int gap);
		gap = 0;
		while (arm_int_n !== 1'b0) begin
			if (cyc - rst_cyc < `COMMU_T_POR)
				check_int(1'b1, 8'h00);
			gap++;
			step();
		end
		if (cyc - rst_cyc < `COMMU_T_POR) begin
			$display("interrupt raised %0d cycles after reset, inside the power-on delay",
				cyc - rst_cyc);
			abort_run();
		end
		check_int(1'b0, 8'hff);
	endtask

	task automatic read_word(input logic exp_valid, input commu_pkg::pkt_word_t exp);
		rd_req = 1'b1;
		step();
		rd_req = 1'b0;
		check_valid(exp_valid);
		if (exp_valid)
			check_word(exp);
		step();
	endtask

	task automatic serve_pkt();
		int len;
		len = len_q.pop_front();
		for (int i = 0; i < len; i++)
			read_word(1'b1, ref_q.pop_front());
		// one request past the end
		read_word(1'b0, '0);
		buf_frm = 1'b1;
		step();
		while (arm_int_n !== 1'b1)
			step();
		buf_frm = 1'b0;
		check_int(1'b1, 8'h00);
		check_cnt(commu_pkg::pkt_cnt_t'(len_q.size()));
	endtask

	task automatic run_entry(input entry_t e);
		int gap;
		int held;
		for (int i = 0; i < e.npkt; i++)
			send_pkt(int'(e.len));
		step();
		check_cnt(e.exp_cnt);
		if (e.mode == MODE_WDOG) begin
			wait_int_low(gap);
			held = 0;
			while (arm_int_n === 1'b0) begin
				held = low_run + 1;
				step();
			end
			check_span("arm_int_n low cycles", held, `COMMU_T_WD, `COMMU_T_WD);
			check_cnt('0);
			ref_q.delete();
			len_q.delete();
		end else begin
			for (int k = 0; len_q.size() > 0; k++) begin
				wait_int_low(gap);
				if (k > 0)
					check_span("arm_int_n holdoff cycles", gap, `COMMU_T_DOWN,
						`COMMU_T_DOWN + 4);
				serve_pkt();
			end
		end
	endtask

	initial begin
		rst_n    = 1'b0;
		repk_frm = 1'b0;
		wr_valid = 1'b0;
		wr_data  = '0;
		rd_req   = 1'b0;
		buf_frm  = 1'b0;
		lfsr     = 32'h98fd;
		repeat (16) @(posedge clk_sys);
		#10;
		rst_n   = 1'b1;
		rst_cyc = cyc;
		check_int(1'b1, 8'h00);
		check_valid(1'b0);
		check_cnt('0);
		for (int n = 0; n < N_ENTRIES; n++)
			run_entry(STIM[n]);
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire
